/* design/cartoonPkg.sv */
/* Shared sizes, types, register map and reset values of the cartoon filter.
   Every RTL module imports this package by wildcard. */
`default_nettype none

package cartoonPkg;

	// ========================================================================
	// Frame geometry
	// ========================================================================
	localparam int FrameWidth  = 16;
	localparam int FrameHeight = 12;

	// Pixels swallowed before the window centre is real
	localparam int PrimeCount = FrameWidth + 1;

	// ========================================================================
	// Data path types
	// ========================================================================
	typedef logic [4:0]  chanT;
	// Red 14:10, green 9:5, blue 4:0
	typedef logic [14:0] pixelT;
	// r + 2g + b, max 124
	typedef logic [6:0]  lumaT;
	// Gradient magnitude, max 496
	typedef logic [8:0]  gradT;
	typedef logic [3:0]  colT;
	typedef logic [3:0]  rowT;
	// Fill counter wide enough to hold PrimeCount
	typedef logic [$clog2(PrimeCount + 1) - 1:0] fillT;

	// Last centre position in a line and in a frame
	localparam colT LastCol = colT'(FrameWidth - 1);
	localparam rowT LastRow = rowT'(FrameHeight - 1);

	// ========================================================================
	// Wishbone register map
	// ========================================================================
	typedef logic [1:0]  wbAdrT;
	typedef logic [15:0] wbDatT;

	localparam wbAdrT AdrMask   = 2'd0;
	localparam wbAdrT AdrThresh = 2'd1;
	localparam wbAdrT AdrMode   = 2'd2;

	// Keep top three red, four green, three blue bits
	localparam wbDatT MaskReset   = {1'b0, 5'b11100, 5'b11110, 5'b11100};
	localparam gradT  ThreshReset = 9'd224;

	// Classic slave handshake
	typedef enum logic {
		CfgIdle,
		CfgAck
	} cfgStateT;

endpackage

`default_nettype wire

/* design/wbConfigSlave.sv */
/* Wishbone classic slave holding the colour masks, edge threshold and mode bits.
   Acknowledges one cycle after a request and writes at the acknowledge edge. */
`timescale 1ns/1ns
`default_nettype none

module wbConfigSlave import cartoonPkg::*; (
	input  wire    VGA_CTRL_CLK,
	input  wire    DLY_RST_2,
	input  wire    wbCyc,
	input  wire    wbStb,
	input  wire    wbWe,
	input  wbAdrT  wbAdr,
	input  wbDatT  wbDatIn,
	output wbDatT  wbDatOut,
	output logic   wbAck,
	output chanT   redMask,
	output chanT   greenMask,
	output chanT   blueMask,
	output gradT   edgeThresh,
	output logic   grayMode,
	output logic   fillMode
);

	cfgStateT cfgState;

	// Idle sees request, ack for one cycle, then back to idle
	always_ff @(posedge VGA_CTRL_CLK or negedge DLY_RST_2) begin
		if (!DLY_RST_2) begin
			cfgState <= CfgIdle;
		end else begin
			case (cfgState)
				CfgIdle: if (wbCyc && wbStb) cfgState <= CfgAck;
				CfgAck:  cfgState <= CfgIdle;
				default: cfgState <= CfgIdle;
			endcase
		end
	end

	assign wbAck = (cfgState == CfgAck);

	// Register writes land on the acknowledge edge
	always_ff @(posedge VGA_CTRL_CLK or negedge DLY_RST_2) begin
		if (!DLY_RST_2) begin
			redMask    <= MaskReset[14:10];
			greenMask  <= MaskReset[9:5];
			blueMask   <= MaskReset[4:0];
			edgeThresh <= ThreshReset;
			grayMode   <= 1'b0;
			fillMode   <= 1'b0;
		end else if (wbAck && wbCyc && wbStb && wbWe) begin
			case (wbAdr)
				AdrMask: begin
					redMask   <= wbDatIn[14:10];
					greenMask <= wbDatIn[9:5];
					blueMask  <= wbDatIn[4:0];
				end
				AdrThresh: edgeThresh <= wbDatIn[8:0];
				AdrMode: begin
					grayMode <= wbDatIn[0];
					fillMode <= wbDatIn[1];
				end
				// Unknown address, write dropped
				default: ;
			endcase
		end
	end

	// Read data follows the address, sampled by the master with ack
	always_comb begin
		case (wbAdr)
			AdrMask:   wbDatOut = {1'b0, redMask, greenMask, blueMask};
			AdrThresh: wbDatOut = {7'b0, edgeThresh};
			AdrMode:   wbDatOut = {14'b0, fillMode, grayMode};
			default:   wbDatOut = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/rasterCounter.sv */
/* Counts the pipeline fill after reset, then follows the raster position of the
   window centre so that edges are suppressed on the frame border. */
`timescale 1ns/1ns
`default_nettype none

module rasterCounter import cartoonPkg::*; (
	input  wire   VGA_CTRL_CLK,
	input  wire   DLY_RST_2,
	input  wire   pixValid,
	output logic  primed,
	output logic  edgeAllow
);

	fillT fillCount;
	colT  centreCol;
	rowT  centreRow;

	// ========================================================================
	// Fill counter
	// ========================================================================
	// Saturates once the centre holds pixel zero of the stream
	always_ff @(posedge VGA_CTRL_CLK or negedge DLY_RST_2) begin
		if (!DLY_RST_2) begin
			fillCount <= '0;
		end else if (pixValid && !primed) begin
			fillCount <= fillCount + 1'b1;
		end
	end

	assign primed = (fillCount == fillT'(PrimeCount));

	// ========================================================================
	// Centre position
	// ========================================================================
	// Starts on the last position so the first step wraps to 0,0
	always_ff @(posedge VGA_CTRL_CLK or negedge DLY_RST_2) begin
		if (!DLY_RST_2) begin
			centreCol <= LastCol;
			centreRow <= LastRow;
		end else if (pixValid && primed) begin
			if (centreCol == LastCol) begin
				centreCol <= '0;
				centreRow <= (centreRow == LastRow) ? '0 : centreRow + 1'b1;
			end else begin
				centreCol <= centreCol + 1'b1;
			end
		end
	end

	// Border centres would see pixels of another line or frame
	assign edgeAllow = (centreCol != '0) && (centreCol != LastCol) &&
		(centreRow != '0) && (centreRow != LastRow);

endmodule

`default_nettype wire

/* design/lineWindow.sv */
/* Two line delays and the 3x3 pixel window, advanced on every accepted pixel.
   Window index 0 is top left, 4 the centre and 8 the newest pixel. */
`timescale 1ns/1ns
`default_nettype none

module lineWindow import cartoonPkg::*; (
	input  wire          VGA_CTRL_CLK,
	input  wire          DLY_RST_2,
	input  wire          pixValid,
	input  pixelT        pixIn,
	input  wire          primed,
	output pixelT [8:0]  window,
	output logic         winValid
);

	// Line 0 delays the input, line 1 delays the output of line 0
	pixelT lineBuf [2][FrameWidth];

	// ========================================================================
	// Line delays
	// ========================================================================
	always_ff @(posedge VGA_CTRL_CLK) begin
		if (pixValid) begin
			lineBuf[0][0] <= pixIn;
			lineBuf[1][0] <= lineBuf[0][FrameWidth - 1];
			for (int i = 1; i < FrameWidth; i++) begin
				lineBuf[0][i] <= lineBuf[0][i - 1];
				lineBuf[1][i] <= lineBuf[1][i - 1];
			end
		end
	end

	// ========================================================================
	// 3x3 window
	// ========================================================================
	always_ff @(posedge VGA_CTRL_CLK) begin
		if (pixValid) begin
			// Right column takes the newest pixel of each line
			window[8] <= pixIn;
			window[5] <= lineBuf[0][FrameWidth - 1];
			window[2] <= lineBuf[1][FrameWidth - 1];
			// Older columns slide left
			for (int r = 0; r < 3; r++) begin
				window[3 * r]     <= window[3 * r + 1];
				window[3 * r + 1] <= window[3 * r + 2];
			end
		end
	end

	// Window content is real only once the fill is done
	always_ff @(posedge VGA_CTRL_CLK or negedge DLY_RST_2) begin
		if (!DLY_RST_2) begin
			winValid <= 1'b0;
		end else begin
			winValid <= pixValid && primed;
		end
	end

endmodule

`default_nettype wire

/* design/edgeDetect.sv */
/* Intensity of the nine window pixels and the row and column gradients.
   Purely combinational, flags an edge above the programmed threshold. */
`timescale 1ns/1ns
`default_nettype none

module edgeDetect import cartoonPkg::*; (
	input  pixelT [8:0]  window,
	input  gradT         edgeThresh,
	input  wire          edgeAllow,
	output logic         isEdge,
	output lumaT         centreLuma
);

	lumaT luma [9];
	gradT topSum;
	gradT bottomSum;
	gradT leftSum;
	gradT rightSum;
	gradT gradH;
	gradT gradV;

	// r + 2g + b
	function automatic lumaT lumaOf(pixelT p);
		return {2'b0, p[14:10]} + {1'b0, p[9:5], 1'b0} + {2'b0, p[4:0]};
	endfunction

	// 1, 2, 1 weighting along a row or column
	function automatic gradT weighted(lumaT a, lumaT b, lumaT c);
		return {2'b0, a} + {1'b0, b, 1'b0} + {2'b0, c};
	endfunction

	function automatic gradT absDiff(gradT x, gradT y);
		return (x > y) ? x - y : y - x;
	endfunction

	always_comb begin
		for (int i = 0; i < 9; i++) begin
			luma[i] = lumaOf(window[i]);
		end
	end

	// ========================================================================
	// Gradients
	// ========================================================================
	// Top row against bottom row
	assign topSum    = weighted(luma[0], luma[1], luma[2]);
	assign bottomSum = weighted(luma[6], luma[7], luma[8]);
	assign gradH     = absDiff(topSum, bottomSum);

	// Left column against right column
	assign leftSum  = weighted(luma[0], luma[3], luma[6]);
	assign rightSum = weighted(luma[2], luma[5], luma[8]);
	assign gradV    = absDiff(leftSum, rightSum);

	// Strictly above threshold, never on the border
	assign isEdge = edgeAllow && ((gradH > edgeThresh) || (gradV > edgeThresh));

	assign centreLuma = luma[4];

endmodule

`default_nettype wire

/* design/colorReduce.sv */
/* Grey or colour source, per-channel bit masking and edge blackening.
   Registers the filtered pixel together with its valid. */
`timescale 1ns/1ns
`default_nettype none

module colorReduce import cartoonPkg::*; (
	input  wire    VGA_CTRL_CLK,
	input  wire    DLY_RST_2,
	input  wire    winValid,
	input  pixelT  centrePixel,
	input  lumaT   centreLuma,
	input  wire    isEdge,
	input  chanT   redMask,
	input  chanT   greenMask,
	input  chanT   blueMask,
	input  wire    grayMode,
	input  wire    fillMode,
	output logic   outValid,
	output pixelT  outPixel
);

	pixelT source;
	pixelT reduced;

	// Fill mode sets the dropped bits instead of clearing them
	function automatic chanT maskChan(chanT c, chanT m, logic fill);
		return fill ? ((c & m) | ~m) : (c & m);
	endfunction

	// Grey uses the upper five intensity bits on all channels
	assign source = grayMode ? {3{centreLuma[6:2]}} : centrePixel;

	assign reduced = isEdge ? '0 : {maskChan(source[14:10], redMask, fillMode),
		maskChan(source[9:5], greenMask, fillMode),
		maskChan(source[4:0], blueMask, fillMode)};

	always_ff @(posedge VGA_CTRL_CLK or negedge DLY_RST_2) begin
		if (!DLY_RST_2) begin
			outValid <= 1'b0;
		end else begin
			outValid <= winValid;
		end
	end

	always_ff @(posedge VGA_CTRL_CLK) begin
		if (winValid) outPixel <= reduced;
	end

endmodule

`default_nettype wire

/* design/cartoonFilter.sv */
/* Cartoon filter top, a streamed RGB pixel in and the filtered pixel two cycles
   later, configured over a Wishbone classic slave. */
`timescale 1ns/1ns
`default_nettype none

module cartoonFilter import cartoonPkg::*; (
	input  wire    VGA_CTRL_CLK,
	input  wire    DLY_RST_2,
	// Pixel stream
	input  wire    pixValid,
	input  pixelT  pixIn,
	output logic   outValid,
	output pixelT  outPixel,
	// Wishbone slave
	input  wire    wbCyc,
	input  wire    wbStb,
	input  wire    wbWe,
	input  wbAdrT  wbAdr,
	input  wbDatT  wbDatIn,
	output wbDatT  wbDatOut,
	output logic   wbAck
);

	chanT         redMask;
	chanT         greenMask;
	chanT         blueMask;
	gradT         edgeThresh;
	logic         grayMode;
	logic         fillMode;
	logic         primed;
	logic         edgeAllow;
	pixelT [8:0]  window;
	logic         winValid;
	logic         isEdge;
	lumaT         centreLuma;

	wbConfigSlave uCfg (.VGA_CTRL_CLK, .DLY_RST_2, .wbCyc, .wbStb, .wbWe, .wbAdr,
		.wbDatIn, .wbDatOut, .wbAck, .redMask, .greenMask, .blueMask, .edgeThresh,
		.grayMode, .fillMode);

	rasterCounter uRaster (.VGA_CTRL_CLK, .DLY_RST_2, .pixValid, .primed, .edgeAllow);

	// Window forms one cycle after the pixel
	lineWindow uWindow (.VGA_CTRL_CLK, .DLY_RST_2, .pixValid, .pixIn, .primed,
		.window, .winValid);

	edgeDetect uEdge (.window, .edgeThresh, .edgeAllow, .isEdge, .centreLuma);

	// Output register, second pipeline stage
	colorReduce uReduce (.VGA_CTRL_CLK, .DLY_RST_2, .winValid,
		.centrePixel(window[4]), .centreLuma, .isEdge, .redMask, .greenMask,
		.blueMask, .grayMode, .fillMode, .outValid, .outPixel);

endmodule

`default_nettype wire

/* sim/tbCartoonFilter.sv */
/* Testbench driving random pixel frames into the cartoon filter against a raster model,
   plus Wishbone register checks and a cycle watchdog. */
`timescale 1ns/1ns
`default_nettype none

module tbCartoonFilter import cartoonPkg::*; ();

	localparam int FrameSize     = FrameWidth * FrameHeight;
	// 3 + 2 + 2 + 1 frames over the five tests
	localparam int TotalPixels   = 8 * FrameSize;
	localparam int TimeoutCycles = TotalPixels * 2 + 200;

	logic   VGA_CTRL_CLK = 1'b0;
	logic   DLY_RST_2;
	logic   pixValid;
	pixelT  pixIn;
	logic   outValid;
	pixelT  outPixel;
	logic   wbCyc;
	logic   wbStb;
	logic   wbWe;
	wbAdrT  wbAdr;
	wbDatT  wbDatIn;
	wbDatT  wbDatOut;
	logic   wbAck;

	// Model state with the accepted stream and pending outputs
	pixelT  history [TotalPixels];
	int     accepted;
	pixelT  expPix [$];
	int     expCycle [$];
	chanT   mRed;
	chanT   mGreen;
	chanT   mBlue;
	gradT   mThresh;
	logic   mGray;
	logic   mFill;

	int     cycles = 0;
	int     outCount;
	int     checks;
	int     errors;
	int     testErrStart;
	int     testsRun;
	int     testsFailed;
	string  testName;
	pixelT  gotExp;
	int     gotCycle;
	wbDatT  rd;

	cartoonFilter DUT (.VGA_CTRL_CLK, .DLY_RST_2, .pixValid, .pixIn, .outValid, .outPixel,
		.wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatIn, .wbDatOut, .wbAck);

	always #50 VGA_CTRL_CLK = ~VGA_CTRL_CLK;

	// Watchdog
	always @(posedge VGA_CTRL_CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("Timeout: the run did not end within %0d cycles", TimeoutCycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ========================================================================
	// Compare tasks
	// ========================================================================
	task automatic checkPixel(input pixelT expected, input pixelT actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s: expected pixel %h, actual %h", testName, expected, actual);
		end
	endtask

	task automatic checkWord(input string what, input wbDatT expected, input wbDatT actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s (%s): expected %h, actual %h", testName, what, expected,
				actual);
		end
	endtask

	// ========================================================================
	// Reference model
	// ========================================================================
	// r + 2g + b
	function automatic int intensity(pixelT p);
		return int'(p[14:10]) + 2 * int'(p[9:5]) + int'(p[4:0]);
	endfunction

	// Kept bits survive, dropped ones clear or set in fill mode
	function automatic chanT maskChannel(int value, chanT mask);
		chanT c;
		c = chanT'(value);
		return mFill ? (c | ~mask) : (c & mask);
	endfunction

	function automatic pixelT expectedPixel(int p);
		int col;
		int row;
		int idx;
		int luma [3][3];
		int gradH;
		int gradV;
		int y;
		col = p % FrameWidth;
		row = (p / FrameWidth) % FrameHeight;
		// Raster neighbours, one line is FrameWidth positions
		for (int dr = 0; dr < 3; dr++) begin
			for (int dc = 0; dc < 3; dc++) begin
				idx = p + (dr - 1) * FrameWidth + dc - 1;
				luma[dr][dc] = (idx >= 0) ? intensity(history[idx]) : 0;
			end
		end
		gradH = (luma[0][0] + 2 * luma[0][1] + luma[0][2]) -
			(luma[2][0] + 2 * luma[2][1] + luma[2][2]);
		gradV = (luma[0][0] + 2 * luma[1][0] + luma[2][0]) -
			(luma[0][2] + 2 * luma[1][2] + luma[2][2]);
		if (gradH < 0) gradH = -gradH;
		if (gradV < 0) gradV = -gradV;
		// Border centres never black
		if (col > 0 && col < FrameWidth - 1 && row > 0 && row < FrameHeight - 1 &&
			(gradH > int'(mThresh) || gradV > int'(mThresh))) begin
			return '0;
		end
		y = intensity(history[p]) / 4;
		if (mGray) begin
			return {maskChannel(y, mRed), maskChannel(y, mGreen), maskChannel(y, mBlue)};
		end
		return {maskChannel(int'(history[p][14:10]), mRed),
			maskChannel(int'(history[p][9:5]), mGreen),
			maskChannel(int'(history[p][4:0]), mBlue)};
	endfunction

	// Black, white or noise, so edges show up at the default threshold
	function automatic pixelT randomPixel();
		case ($urandom % 4)
			0: return '0;
			1: return '1;
			default: return pixelT'($urandom);
		endcase
	endfunction

	// Output monitor sampled away from the rising edge
	always @(negedge VGA_CTRL_CLK) begin
		if (DLY_RST_2 === 1'b1 && outValid === 1'b1) begin
			outCount++;
			if (expPix.size() == 0) begin
				errors++;
				$display("%s: output valid while no pixel was pending", testName);
			end else begin
				gotExp = expPix.pop_front();
				gotCycle = expCycle.pop_front();
				checkPixel(gotExp, outPixel);
				if (cycles - gotCycle != 2) begin
					errors++;
					$display("%s: output came %0d cycles after its input instead of 2",
						testName, cycles - gotCycle);
				end
			end
		end
	end

	// ========================================================================
	// Bus and stream tasks
	// ========================================================================
	task automatic busAccess(input logic we, input wbAdrT adr, input wbDatT dat,
		output wbDatT rdata);
		int waits;
		@(negedge VGA_CTRL_CLK);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatIn = dat;
		// Hold the request until acknowledge
		@(negedge VGA_CTRL_CLK);
		waits = 1;
		while (!wbAck) begin
			@(negedge VGA_CTRL_CLK);
			waits++;
		end
		if (waits != 1) begin
			errors++;
			$display("%s: acknowledge took %0d cycles instead of 1", testName, waits);
		end
		rdata = wbDatOut;
		// Release only after the acknowledge edge has landed a write
		@(negedge VGA_CTRL_CLK);
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		if (wbAck) begin
			errors++;
			$display("%s: acknowledge stayed high for a second cycle", testName);
		end
	endtask

	task automatic busWrite(input wbAdrT adr, input wbDatT dat);
		wbDatT ignored;
		busAccess(1'b1, adr, dat, ignored);
		case (adr)
			AdrMask: begin
				mRed = dat[14:10];
				mGreen = dat[9:5];
				mBlue = dat[4:0];
			end
			AdrThresh: mThresh = dat[8:0];
			AdrMode: begin
				mGray = dat[0];
				mFill = dat[1];
			end
			default: ;
		endcase
	endtask

	task automatic busRead(input wbAdrT adr, output wbDatT dat);
		busAccess(1'b0, adr, '0, dat);
	endtask

	task automatic streamPixels(input int count, input int validPct);
		int sent;
		sent = 0;
		while (sent < count) begin
			@(negedge VGA_CTRL_CLK);
			pixIn = randomPixel();
			pixValid = (int'($urandom % 100) < validPct);
			if (pixValid) begin
				history[accepted] = pixIn;
				// Newest pixel completes the window of the one 17 back
				if (accepted >= PrimeCount) begin
					expPix.push_back(expectedPixel(accepted - PrimeCount));
					expCycle.push_back(cycles);
				end
				accepted++;
				sent++;
			end
		end
		@(negedge VGA_CTRL_CLK);
		pixValid = 1'b0;
		while (expPix.size() != 0) @(posedge VGA_CTRL_CLK);
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrStart = errors;
	endtask

	task automatic finishTest();
		int n;
		n = errors - testErrStart;
		testsRun++;
		if (n != 0) testsFailed++;
		$display("%s: %s, %0d errors", testName, (n == 0) ? "pass" : "fail", n);
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial begin
		// First draw seeds the generator and sets the idle pixel
		pixIn = pixelT'($urandom(21128));
		DLY_RST_2 = 1'b0;
		pixValid = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatIn = '0;
		accepted = 0;
		outCount = 0;
		checks = 0;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;
		testName = "reset";
		// Register reset values
		mRed = 5'b11100;
		mGreen = 5'b11110;
		mBlue = 5'b11100;
		mThresh = 9'd224;
		mGray = 1'b0;
		mFill = 1'b0;
		repeat (3) @(negedge VGA_CTRL_CLK);
		DLY_RST_2 = 1'b1;

		startTest("reset values");
		if (wbAck !== 1'b0 || outValid !== 1'b0) begin
			errors++;
			$display("%s: acknowledge or output valid not low after reset", testName);
		end
		busRead(AdrMask, rd);
		checkWord("mask", {1'b0, 5'b11100, 5'b11110, 5'b11100}, rd);
		busRead(AdrThresh, rd);
		checkWord("threshold", 16'd224, rd);
		busRead(AdrMode, rd);
		checkWord("mode", 16'd0, rd);
		busWrite(AdrThresh, 16'h0155);
		busRead(AdrThresh, rd);
		checkWord("threshold write", 16'h0155, rd);
		busWrite(2'd3, 16'hFFFF);
		busRead(2'd3, rd);
		checkWord("unknown address", 16'h0000, rd);
		busWrite(AdrThresh, 16'd224);
		finishTest();

		startTest("colour reduction");
		streamPixels(3 * FrameSize, 75);
		finishTest();

		startTest("grey and fill modes");
		busWrite(AdrMask, wbDatT'($urandom & 32'h7FFF));
		busWrite(AdrMode, 16'd1);
		streamPixels(FrameSize, 75);
		busWrite(AdrMode, 16'd2);
		streamPixels(FrameSize, 75);
		finishTest();

		startTest("threshold extremes");
		busWrite(AdrMask, {1'b0, 5'b11100, 5'b11110, 5'b11100});
		busWrite(AdrMode, 16'd0);
		busWrite(AdrThresh, 16'd0);
		streamPixels(FrameSize, 75);
		// Above the largest possible gradient
		busWrite(AdrThresh, 16'h01FF);
		streamPixels(FrameSize, 75);
		finishTest();

		startTest("output count and order");
		streamPixels(FrameSize, 50);
		if (outCount != accepted - PrimeCount) begin
			errors++;
			$display("%s: %0d outputs seen for %0d accepted pixels", testName, outCount,
				accepted);
		end
		finishTest();

		$display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d", testsRun,
			testsFailed, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
design/cartoonPkg.sv
design/wbConfigSlave.sv
design/rasterCounter.sv
design/lineWindow.sv
design/edgeDetect.sv
design/colorReduce.sv
design/cartoonFilter.sv
sim/tbCartoonFilter.sv

/* Makefile */
# Verilator build and run of the cartoon filter testbench
TOP := tbCartoonFilter

obj_dir/V$(TOP): sim.f $(wildcard design/*.sv sim/*.sv)
	verilator --binary --timing --timescale 1ns/1ns -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: run clean
